// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP        := mem_island_tb
FILELIST   := list.f
OBJDIR     := obj_dir
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== list.f ====
+incdir+src
src/mem_island_pkg.sv
src/narrow_router.sv
src/wide_splitter.sv
src/bank_arbiter.sv
src/sram_bank.sv
src/mem_island_top.sv
test/mem_island_assert.sv
test/mem_island_tb.sv

// ==== src/bank_arbiter.sv ====
// Bank arbiter
// Per-bank selection between the narrow and wide requests, narrow first.
// The wide request is granted only when its whole group is free.

`timescale 1ns/1ps
`include "mem_island_consts.svh"

module bank_arbiter import mem_island_pkg::*; (
    input  bank_req_t [`MI_NUM_BANKS-1:0] narrow_req_i,
    input  bank_req_t [`MI_NUM_BANKS-1:0] wide_req_i,
    output bank_req_t [`MI_NUM_BANKS-1:0] bank_req_o,
    output logic                          wide_gnt_o
);

    logic [`MI_NUM_BANKS-1:0] wide_en;
    logic [`MI_NUM_BANKS-1:0] conflict;

    // ------------------------------------------------------------------------
    // Conflict detection
    // ------------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < `MI_NUM_BANKS; b++) begin
            wide_en[b]  = wide_req_i[b].en;
            // Both sides want the same bank
            conflict[b] = narrow_req_i[b].en && wide_req_i[b].en;
        end
    end

    // Any clash anywhere stalls the whole wide access
    assign wide_gnt_o = (|wide_en) && !(|conflict);

    // ------------------------------------------------------------------------
    // Bank request mux
    // ------------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < `MI_NUM_BANKS; b++) begin
            if (narrow_req_i[b].en) begin
                bank_req_o[b] = narrow_req_i[b];
            end else if (wide_gnt_o) begin
                // Granted slice
                bank_req_o[b] = wide_req_i[b];
            end else begin
                // Idle bank, no partial wide write
                bank_req_o[b] = '0;
            end
        end
    end

endmodule : bank_arbiter

// ==== src/mem_island_consts.svh ====
// Memory island constants
// Widths, bank counts and address bit positions shared by the whole island
// Eight 32-bit banks, word interleaved, grouped in fours for 128-bit access

`ifndef MEM_ISLAND_CONSTS_SVH
`define MEM_ISLAND_CONSTS_SVH

// Byte address covering 2 KiB
`define MI_ADDR_WIDTH 11

// Port data widths
`define MI_NARROW_WIDTH 32
`define MI_WIDE_WIDTH 128
`define MI_NARROW_STRB_WIDTH 4
`define MI_WIDE_STRB_WIDTH 16

// Banking
`define MI_NUM_BANKS 8
`define MI_SLICES 4
`define MI_NUM_WIDE_BANKS 2
`define MI_WORDS_PER_BANK 64
`define MI_BANK_ADDR_WIDTH 6
`define MI_BANK_SEL_WIDTH 3

// Address bit positions
`define MI_BANK_SEL_LSB 2
`define MI_WIDE_SEL_BIT 4
`define MI_IN_BANK_LSB 5

`endif

// ==== src/mem_island_pkg.sv ====
// Memory island types
// Vector typedefs and the request, response and bank request structs
// used by the router, splitter, arbiter and banks

`include "mem_island_consts.svh"

package mem_island_pkg;

    // Plain vectors with a meaning
    typedef logic [`MI_ADDR_WIDTH-1:0]        addr_t;
    typedef logic [`MI_NARROW_WIDTH-1:0]      narrow_data_t;
    typedef logic [`MI_NARROW_STRB_WIDTH-1:0] narrow_strb_t;
    typedef logic [`MI_WIDE_WIDTH-1:0]        wide_data_t;
    typedef logic [`MI_WIDE_STRB_WIDTH-1:0]   wide_strb_t;
    typedef logic [`MI_BANK_ADDR_WIDTH-1:0]   bank_addr_t;
    typedef logic [`MI_BANK_SEL_WIDTH-1:0]    bank_sel_t;

    // ------------------------------------------------------------------------
    // Port channels
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic         q_valid;
        logic         write;
        addr_t        addr;
        narrow_data_t wdata;
        narrow_strb_t strb;
    } narrow_req_t;

    typedef struct packed {
        logic       q_valid;
        logic       write;
        addr_t      addr;
        wide_data_t wdata;
        wide_strb_t strb;
    } wide_req_t;

    typedef struct packed {
        logic         q_ready;
        logic         p_valid;
        narrow_data_t rdata;
    } narrow_rsp_t;

    typedef struct packed {
        logic       q_ready;
        logic       p_valid;
        wide_data_t rdata;
    } wide_rsp_t;

    // One access to a single bank
    typedef struct packed {
        logic         en;
        logic         we;
        bank_addr_t   addr;
        narrow_data_t wdata;
        narrow_strb_t strb;
    } bank_req_t;

endpackage : mem_island_pkg

// ==== src/mem_island_top.sv ====
// Memory island top
// Narrow 32-bit and wide 128-bit ports onto eight interleaved SRAM banks.
// Narrow requests win bank conflicts and the wide request waits whole.
// Both ports answer one cycle after acceptance.

`timescale 1ns/1ps
`include "mem_island_consts.svh"

module mem_island_top import mem_island_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  narrow_req_t narrow_req_i,
    output narrow_rsp_t narrow_rsp_o,
    input  wide_req_t   wide_req_i,
    output wide_rsp_t   wide_rsp_o
);

    // Per-bank requests from each side
    bank_req_t    [`MI_NUM_BANKS-1:0] narrow_bank_req;
    bank_req_t    [`MI_NUM_BANKS-1:0] wide_bank_req;

    // Arbitrated bank requests
    bank_req_t    [`MI_NUM_BANKS-1:0] bank_req;

    // Read data shared by both sides
    narrow_data_t [`MI_NUM_BANKS-1:0] bank_rdata;

    logic                             wide_gnt;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    narrow_router i_narrow_router (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (narrow_req_i),
        .rsp_o        (narrow_rsp_o),
        .bank_req_o   (narrow_bank_req),
        .bank_rdata_i (bank_rdata)
    );

    wide_splitter i_wide_splitter (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (wide_req_i),
        .rsp_o        (wide_rsp_o),
        .gnt_i        (wide_gnt),
        .bank_req_o   (wide_bank_req),
        .bank_rdata_i (bank_rdata)
    );

    // ------------------------------------------------------------------------
    // Narrow and wide arbitration
    // ------------------------------------------------------------------------
    bank_arbiter i_bank_arbiter (
        .narrow_req_i (narrow_bank_req),
        .wide_req_i   (wide_bank_req),
        .bank_req_o   (bank_req),
        .wide_gnt_o   (wide_gnt)
    );

    // ------------------------------------------------------------------------
    // Banks
    // ------------------------------------------------------------------------
    // Word interleaved, bank index from address bits 4..2
    for (genvar b = 0; b < `MI_NUM_BANKS; b++) begin : gen_banks
        sram_bank i_sram_bank (
            .clk_i   (clk_i),
            .req_i   (bank_req[b]),
            .rdata_o (bank_rdata[b])
        );
    end

endmodule : mem_island_top

// ==== src/narrow_router.sv ====
// Narrow router
// Decodes the narrow byte address to one bank and forms its request.
// Read data of the accessed bank is returned one cycle after acceptance.

`timescale 1ns/1ps
`include "mem_island_consts.svh"

module narrow_router import mem_island_pkg::*; (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  narrow_req_t                        req_i,
    output narrow_rsp_t                        rsp_o,
    output bank_req_t    [`MI_NUM_BANKS-1:0]   bank_req_o,
    input  narrow_data_t [`MI_NUM_BANKS-1:0]   bank_rdata_i
);

    bank_sel_t  bank_sel;
    bank_addr_t word_addr;
    logic       accept;

    // Registered accept pulse and bank index
    logic       valid_q;
    bank_sel_t  bank_sel_q;

    // Bank from bits 4..2, word from bits 10..5
    assign bank_sel  = req_i.addr[`MI_BANK_SEL_LSB +: `MI_BANK_SEL_WIDTH];
    assign word_addr = req_i.addr[`MI_IN_BANK_LSB +: `MI_BANK_ADDR_WIDTH];

    // Narrow side is never stalled
    assign accept = req_i.q_valid && rsp_o.q_ready;

    // One-hot enable across the banks
    always_comb begin
        for (int b = 0; b < `MI_NUM_BANKS; b++) begin
            bank_req_o[b].en    = req_i.q_valid && (bank_sel == bank_sel_t'(b));
            bank_req_o[b].we    = req_i.write;
            bank_req_o[b].addr  = word_addr;
            bank_req_o[b].wdata = req_i.wdata;
            bank_req_o[b].strb  = req_i.strb;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q    <= 1'b0;
            bank_sel_q <= '0;
        end else begin
            valid_q <= accept;
            // Hold index between accesses
            if (accept) begin
                bank_sel_q <= bank_sel;
            end
        end
    end

    assign rsp_o.q_ready = req_i.q_valid;
    assign rsp_o.p_valid = valid_q;
    // Bank output is registered, so pick it with last cycle's index
    assign rsp_o.rdata   = bank_rdata_i[bank_sel_q];

endmodule : narrow_router

// ==== src/sram_bank.sv ====
// SRAM bank
// Single-port 32-bit word memory with byte strobes.
// Read data is registered and shows the word before a same-cycle write.

`timescale 1ns/1ps
`include "mem_island_consts.svh"

module sram_bank import mem_island_pkg::*; (
    input  logic         clk_i,
    input  bank_req_t    req_i,
    output narrow_data_t rdata_o
);

    localparam int unsigned num_bytes = `MI_NARROW_WIDTH / 8;

    // Storage array
    narrow_data_t mem_q [`MI_WORDS_PER_BANK];

    always_ff @(posedge clk_i) begin
        if (req_i.en) begin
            // Byte-masked write
            if (req_i.we) begin
                for (int i = 0; i < num_bytes; i++) begin
                    if (req_i.strb[i]) begin
                        mem_q[req_i.addr][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                    end
                end
            end
            // Old contents on every access
            rdata_o <= mem_q[req_i.addr];
        end
    end

endmodule : sram_bank

// ==== src/wide_splitter.sv ====
// Wide splitter
// Splits a 128-bit request into four 32-bit slices placed on one bank group
// and rebuilds the wide read word from that group one cycle later.

`timescale 1ns/1ps
`include "mem_island_consts.svh"

module wide_splitter import mem_island_pkg::*; (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  wide_req_t                          req_i,
    output wide_rsp_t                          rsp_o,
    input  logic                               gnt_i,
    output bank_req_t    [`MI_NUM_BANKS-1:0]   bank_req_o,
    input  narrow_data_t [`MI_NUM_BANKS-1:0]   bank_rdata_i
);

    localparam int unsigned group_width = $clog2(`MI_NUM_WIDE_BANKS);

    logic [group_width-1:0] group;
    bank_addr_t             word_addr;
    logic                   accept;

    // Registered accept pulse and group
    logic                   valid_q;
    logic [group_width-1:0] group_q;

    assign group     = req_i.addr[`MI_WIDE_SEL_BIT +: group_width];
    assign word_addr = req_i.addr[`MI_IN_BANK_LSB +: `MI_BANK_ADDR_WIDTH];

    // Grant is all or nothing
    assign accept = req_i.q_valid && gnt_i;

    // ------------------------------------------------------------------------
    // Request slicing
    // ------------------------------------------------------------------------
    // Bank b is slice b mod 4 of group b div 4
    always_comb begin
        for (int b = 0; b < `MI_NUM_BANKS; b++) begin
            bank_req_o[b].en    = req_i.q_valid && ((b / `MI_SLICES) == int'(group));
            bank_req_o[b].we    = req_i.write;
            bank_req_o[b].addr  = word_addr;
            bank_req_o[b].wdata =
                req_i.wdata[(b % `MI_SLICES) * `MI_NARROW_WIDTH +: `MI_NARROW_WIDTH];
            bank_req_o[b].strb  =
                req_i.strb[(b % `MI_SLICES) * `MI_NARROW_STRB_WIDTH +: `MI_NARROW_STRB_WIDTH];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            group_q <= '0;
        end else begin
            valid_q <= accept;
            if (accept) begin
                group_q <= group;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Response assembly
    // ------------------------------------------------------------------------
    // Lowest bank of the group lands in the lowest slice
    always_comb begin
        for (int s = 0; s < `MI_SLICES; s++) begin
            rsp_o.rdata[s * `MI_NARROW_WIDTH +: `MI_NARROW_WIDTH] =
                bank_rdata_i[bank_sel_t'(int'(group_q) * `MI_SLICES + s)];
        end
    end

    assign rsp_o.q_ready = gnt_i;
    assign rsp_o.p_valid = valid_q;

endmodule : wide_splitter

// ==== test/mem_island_assert.sv ====
// Memory island protocol assertions
// Bound to the top level, checks response timing on both ports

`timescale 1ns/1ps

module mem_island_assert import mem_island_pkg::*; (
    input logic        clk_i,
    input logic        arst_n_i,
    input narrow_req_t narrow_req_i,
    input narrow_rsp_t narrow_rsp_i,
    input wide_req_t   wide_req_i,
    input wide_rsp_t   wide_rsp_i
);

    logic narrow_accept;
    logic wide_accept;

    // Running count of failed properties
    int   fail_count = 0;

    // Handshake on each port
    assign narrow_accept = narrow_req_i.q_valid && narrow_rsp_i.q_ready;
    assign wide_accept   = wide_req_i.q_valid && wide_rsp_i.q_ready;

    narrow_rsp_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        narrow_accept |=> narrow_rsp_i.p_valid)
        else begin
            fail_count++;
            $error("narrow response missing one cycle after acceptance");
        end

    narrow_rsp_needs_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        narrow_rsp_i.p_valid |-> $past(narrow_accept))
        else begin
            fail_count++;
            $error("narrow response without an accepted request");
        end

    wide_rsp_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wide_accept |=> wide_rsp_i.p_valid)
        else begin
            fail_count++;
            $error("wide response missing one cycle after acceptance");
        end

    wide_rsp_needs_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wide_rsp_i.p_valid |-> $past(wide_accept))
        else begin
            fail_count++;
            $error("wide response without an accepted request");
        end

    // Narrow side never stalls
    narrow_ready_is_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        narrow_rsp_i.q_ready == narrow_req_i.q_valid)
        else begin
            fail_count++;
            $error("narrow ready differs from narrow valid");
        end

endmodule : mem_island_assert

bind mem_island_top mem_island_assert mem_island_assert_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .narrow_req_i (narrow_req_i),
    .narrow_rsp_i (narrow_rsp_o),
    .wide_req_i   (wide_req_i),
    .wide_rsp_i   (wide_rsp_o)
);

// ==== test/mem_island_tb.sv ====
// Memory island testbench
// Table-driven narrow and wide traffic with checks of the one-cycle
// responses, stalls on bank conflicts and a cycle limit on the run

`timescale 1ns/1ps

module mem_island_tb import mem_island_pkg::*; ();

    // Operation codes used in the table
    localparam logic [1:0] op_idle = 2'd0;
    localparam logic [1:0] op_rd   = 2'd1;
    localparam logic [1:0] op_wr   = 2'd2;

    // One table entry, applied for one cycle
    typedef struct packed {
        logic [1:0]   n_op;
        addr_t        n_addr;
        narrow_data_t n_wdata;
        narrow_strb_t n_strb;
        logic [1:0]   w_op;
        addr_t        w_addr;
        wide_data_t   w_wdata;
        wide_strb_t   w_strb;
        logic         exp_rdy;
        narrow_data_t exp_n;
        wide_data_t   exp_w;
        logic         chk_n;
        logic         chk_w;
    } step_t;

    logic        clk_i;
    logic        arst_n_i;
    narrow_req_t narrow_req;
    narrow_rsp_t narrow_rsp;
    wide_req_t   wide_req;
    wide_rsp_t   wide_rsp;

    step_t       steps[$];
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit;
    int          assert_fails;

    mem_island_top mem_island_top_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .narrow_req_i (narrow_req),
        .narrow_rsp_o (narrow_rsp),
        .wide_req_i   (wide_req),
        .wide_rsp_o   (wide_rsp)
    );

    // 4 ns clock
    always #2 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no end of test after %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // Read results are checked only for reads, and for wide only when granted
    task automatic add_step(input logic [1:0] n_op, input addr_t n_addr,
                            input narrow_data_t n_wdata, input narrow_strb_t n_strb,
                            input logic [1:0] w_op, input addr_t w_addr,
                            input wide_data_t w_wdata, input wide_strb_t w_strb,
                            input logic exp_rdy, input narrow_data_t exp_n,
                            input wide_data_t exp_w);
        step_t s;
        s = '{n_op, n_addr, n_wdata, n_strb, w_op, w_addr, w_wdata, w_strb,
              exp_rdy, exp_n, exp_w, n_op == op_rd, (w_op == op_rd) && exp_rdy};
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input wide_data_t exp,
                               input wide_data_t got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s exp %0h got %0h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic drive_step(input step_t s);
        narrow_req.q_valid = (s.n_op != op_idle);
        narrow_req.write   = (s.n_op == op_wr);
        narrow_req.addr    = s.n_addr;
        narrow_req.wdata   = s.n_wdata;
        narrow_req.strb    = s.n_strb;
        wide_req.q_valid   = (s.w_op != op_idle);
        wide_req.write     = (s.w_op == op_wr);
        wide_req.addr      = s.w_addr;
        wide_req.wdata     = s.w_wdata;
        wide_req.strb      = s.w_strb;
    endtask

    // Response of the entry accepted one cycle earlier
    task automatic check_response(input step_t s);
        check_value("narrow_rsp_o.p_valid", wide_data_t'(s.n_op != op_idle),
                    wide_data_t'(narrow_rsp.p_valid));
        check_value("wide_rsp_o.p_valid", wide_data_t'((s.w_op != op_idle) && s.exp_rdy),
                    wide_data_t'(wide_rsp.p_valid));
        if (s.chk_n) begin
            check_value("narrow_rsp_o.rdata", wide_data_t'(s.exp_n),
                        wide_data_t'(narrow_rsp.rdata));
        end
        if (s.chk_w) begin
            check_value("wide_rsp_o.rdata", s.exp_w, wide_rsp.rdata);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    task automatic build_table();
        // Byte merge in bank 1, word 2
        add_step(op_wr, 11'h044, 32'h1122_3344, 4'hF, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_wr, 11'h044, 32'hAABB_CCDD, 4'h5, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_rd, 11'h044, '0, '0, op_idle, '0, '0, '0, 1'b0, 32'h11BB_33DD, '0);
        // Wide write to group 1, word 3, read back slice by slice
        add_step(op_idle, '0, '0, '0, op_wr, 11'h070,
                 128'hDDDD0003_CCCC0002_BBBB0001_AAAA0000, 16'hFFFF, 1'b1, '0, '0);
        add_step(op_rd, 11'h070, '0, '0, op_idle, '0, '0, '0, 1'b0, 32'hAAAA_0000, '0);
        add_step(op_rd, 11'h074, '0, '0, op_idle, '0, '0, '0, 1'b0, 32'hBBBB_0001, '0);
        add_step(op_rd, 11'h078, '0, '0, op_idle, '0, '0, '0, 1'b0, 32'hCCCC_0002, '0);
        add_step(op_rd, 11'h07C, '0, '0, op_idle, '0, '0, '0, 1'b0, 32'hDDDD_0003, '0);
        // Banks 0 to 3, word 5, then one wide read
        add_step(op_wr, 11'h0A0, 32'hC0DE_0000, 4'hF, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_wr, 11'h0A4, 32'hC0DE_0001, 4'hF, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_wr, 11'h0A8, 32'hC0DE_0002, 4'hF, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_wr, 11'h0AC, 32'hC0DE_0003, 4'hF, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_idle, '0, '0, '0, op_rd, 11'h0A0, '0, '0, 1'b1, '0,
                 128'hC0DE0003_C0DE0002_C0DE0001_C0DE0000);
        // Preset group 0, word 7
        add_step(op_idle, '0, '0, '0, op_wr, 11'h0E0,
                 128'h11111113_11111112_11111111_11111110, 16'hFFFF, 1'b1, '0, '0);
        // Conflict on bank 2, then on bank 0, then the wide write goes through
        add_step(op_wr, 11'h0E8, 32'h7777_7777, 4'hF, op_wr, 11'h0E0,
                 128'h22222223_22222222_22222221_22222220, 16'h00FF, 1'b0, '0, '0);
        add_step(op_rd, 11'h0E0, '0, '0, op_wr, 11'h0E0,
                 128'h22222223_22222222_22222221_22222220, 16'h00FF, 1'b0,
                 32'h1111_1110, '0);
        add_step(op_idle, '0, '0, '0, op_wr, 11'h0E0,
                 128'h22222223_22222222_22222221_22222220, 16'h00FF, 1'b1, '0, '0);
        add_step(op_idle, '0, '0, '0, op_rd, 11'h0E0, '0, '0, 1'b1, '0,
                 128'h11111113_77777777_22222221_22222220);
        // Narrow in group 1 and wide in group 0 together
        add_step(op_wr, 11'h134, 32'h5A5A_5A5A, 4'hF, op_wr, 11'h120,
                 128'h3C3C3C33_3C3C3C32_3C3C3C31_3C3C3C30, 16'hFFFF, 1'b1, '0, '0);
        add_step(op_rd, 11'h134, '0, '0, op_rd, 11'h120, '0, '0, 1'b1, 32'h5A5A_5A5A,
                 128'h3C3C3C33_3C3C3C32_3C3C3C31_3C3C3C30);
        add_step(op_rd, 11'h044, '0, '0, op_rd, 11'h070, '0, '0, 1'b1, 32'h11BB_33DD,
                 128'hDDDD0003_CCCC0002_BBBB0001_AAAA0000);
        // No strobes, no change
        add_step(op_wr, 11'h044, 32'hFFFF_FFFF, 4'h0, op_idle, '0, '0, '0, 1'b0, '0, '0);
        add_step(op_rd, 11'h044, '0, '0, op_idle, '0, '0, '0, 1'b0, 32'h11BB_33DD, '0);
        add_step(op_idle, '0, '0, '0, op_idle, '0, '0, '0, 1'b0, '0, '0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk_i      = 1'b0;
        arst_n_i   = 1'b0;
        narrow_req = '0;
        wide_req   = '0;
        build_table();
        cycle_limit = 4 * steps.size() + 20;
        // Quiet outputs while in reset
        repeat (4) begin
            @(posedge clk_i);
            #0.5;
            check_value("narrow_rsp_o.p_valid", '0, wide_data_t'(narrow_rsp.p_valid));
            check_value("wide_rsp_o.p_valid", '0, wide_data_t'(wide_rsp.p_valid));
        end
        arst_n_i = 1'b1;
        // One entry per cycle, last pass only collects the final response
        for (int i = 0; i <= steps.size(); i++) begin
            @(posedge clk_i);
            #0.5;
            if (i > 0) begin
                check_response(steps[i-1]);
            end
            if (i < steps.size()) begin
                drive_step(steps[i]);
                #1;
                check_value("narrow_rsp_o.q_ready", wide_data_t'(steps[i].n_op != op_idle),
                            wide_data_t'(narrow_rsp.q_ready));
                check_value("wide_rsp_o.q_ready", wide_data_t'(steps[i].exp_rdy),
                            wide_data_t'(wide_rsp.q_ready));
            end else begin
                narrow_req = '0;
                wide_req   = '0;
            end
        end
        // Protocol properties failed in the bound checker
        assert_fails = mem_island_top_i.mem_island_assert_i.fail_count;
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : mem_island_tb
